// ==== source/uartPkg.sv ====
package uartPkg;

    // one start bit, eight data bits LSB first, one stop bit
    localparam int DATA_BITS = 8;

    // bit period in clocks is 2**accWidth / increment
    // defaults: 256 / 16 = 16 clocks per bit
    localparam int DEFAULT_ACC_WIDTH = 8;
    localparam int DEFAULT_INCREMENT = 16;

    // receiver waits this long after the falling edge
    // to land in the middle of the start bit
    localparam int DEFAULT_HALF_BIT = 8;

    // transmit request into the transmitter
    typedef struct packed {
        // one-cycle strobe, ignored while busy
        logic start;
        logic [DATA_BITS-1:0] data;
    } txReq;

    // receiver result
    typedef struct packed {
        // one-cycle pulse per good frame
        logic valid;
        // one-cycle pulse when the stop bit reads low
        logic frameError;
        // last good byte, held until the next one
        logic [DATA_BITS-1:0] data;
    } rxResult;

endpackage

// ==== source/baudTick.sv ====
`timescale 1ns/1ps

module baudTick #(
    parameter int accWidth = uartPkg::DEFAULT_ACC_WIDTH,
    parameter int increment = uartPkg::DEFAULT_INCREMENT
) (
    input logic clk,
    input logic rst,
    input logic restart,
    output logic tick
);

    localparam logic [accWidth:0] stepSize = (accWidth + 1)'(increment);

    logic [accWidth-1:0] acc;
    // one bit wider so the carry out is visible
    logic [accWidth:0] accSum;

    assign accSum = {1'b0, acc} + stepSize;

    // carry of this cycle's add, so a tick lands exactly
    // 2**accWidth / increment cycles after a restart
    assign tick = accSum[accWidth];

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            acc <= '0;
        end else begin
            // fraction left over after a carry is kept
            acc <= accSum[accWidth-1:0];
        end
    end

endmodule

// ==== source/uartTx.sv ====
`timescale 1ns/1ps

module uartTx #(
    parameter int accWidth = uartPkg::DEFAULT_ACC_WIDTH,
    parameter int baudIncrement = uartPkg::DEFAULT_INCREMENT
) (
    input logic clk,
    input logic rst,
    input uartPkg::txReq tx,
    output logic txLine,
    output logic txBusy
);

    // counts 0..DATA_BITS, the last value marks the stop bit
    localparam int idxWidth = $clog2(uartPkg::DATA_BITS + 1);

    typedef enum logic [1:0] {
        idleState,
        dataState,
        stopState
    } txState;

    txState state;
    logic [idxWidth-1:0] bitIdx;
    logic [uartPkg::DATA_BITS-1:0] shiftReg;
    logic tick;
    logic accept;

    // a start strobe only counts while idle
    assign accept = (state == idleState) && tx.start;
    assign txBusy = (state != idleState);

    // restarted on accept so the start bit gets a full period
    baudTick #(
        .accWidth(accWidth),
        .increment(baudIncrement)
    ) bitTimer (
        .clk(clk),
        .rst(rst),
        .restart(accept),
        .tick(tick)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idleState;
            txLine <= 1'b1;
            bitIdx <= '0;
        end else begin
            case (state)
                idleState: begin
                    txLine <= 1'b1;
                    if (accept) begin
                        // start bit
                        txLine <= 1'b0;
                        bitIdx <= '0;
                        state <= dataState;
                    end
                end
                dataState: begin
                    if (tick) begin
                        if (bitIdx == idxWidth'(uartPkg::DATA_BITS)) begin
                            // all data out, drive the stop bit
                            txLine <= 1'b1;
                            state <= stopState;
                        end else begin
                            txLine <= shiftReg[0];
                            bitIdx <= bitIdx + 1'b1;
                        end
                    end
                end
                stopState: begin
                    // end of the stop bit releases busy
                    if (tick) begin
                        state <= idleState;
                    end
                end
                default: state <= idleState;
            endcase
        end
    end

    // latched byte, shifted LSB first as bits go out
    always_ff @(posedge clk) begin
        if (accept) begin
            shiftReg <= tx.data;
        end else if (state == dataState && tick) begin
            shiftReg <= shiftReg >> 1;
        end
    end

endmodule

// ==== source/uartRx.sv ====
`timescale 1ns/1ps

module uartRx #(
    parameter int accWidth = uartPkg::DEFAULT_ACC_WIDTH,
    parameter int baudIncrement = uartPkg::DEFAULT_INCREMENT,
    parameter int halfBitCycles = uartPkg::DEFAULT_HALF_BIT
) (
    input logic clk,
    input logic rst,
    input logic rxLine,
    output uartPkg::rxResult rx
);

    localparam int halfWidth = $clog2(halfBitCycles + 1);
    localparam int idxWidth = $clog2(uartPkg::DATA_BITS);

    typedef enum logic [1:0] {
        idleState,
        halfState,
        dataState,
        stopState
    } rxState;

    rxState state;
    logic [halfWidth-1:0] halfCnt;
    logic [idxWidth-1:0] bitIdx;
    logic [uartPkg::DATA_BITS-1:0] assembly;
    logic tick;
    logic halfDone;
    logic startOk;

    assign halfDone = (state == halfState) && (halfCnt == halfWidth'(halfBitCycles));

    // still low at mid start bit, so a real frame
    assign startOk = halfDone && !rxLine;

    // restart here puts every later tick in the middle of a bit
    baudTick #(
        .accWidth(accWidth),
        .increment(baudIncrement)
    ) bitTimer (
        .clk(clk),
        .rst(rst),
        .restart(startOk),
        .tick(tick)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idleState;
            halfCnt <= '0;
            bitIdx <= '0;
            rx <= '0;
        end else begin
            // result strobes last one cycle
            rx.valid <= 1'b0;
            rx.frameError <= 1'b0;
            case (state)
                idleState: begin
                    if (!rxLine) begin
                        halfCnt <= halfWidth'(1);
                        state <= halfState;
                    end
                end
                halfState: begin
                    halfCnt <= halfCnt + 1'b1;
                    if (startOk) begin
                        bitIdx <= '0;
                        state <= dataState;
                    end else if (halfDone) begin
                        // line went back high, a glitch
                        state <= idleState;
                    end
                end
                dataState: begin
                    if (tick) begin
                        bitIdx <= bitIdx + 1'b1;
                        if (bitIdx == idxWidth'(uartPkg::DATA_BITS - 1)) begin
                            state <= stopState;
                        end
                    end
                end
                stopState: begin
                    if (tick) begin
                        if (rxLine) begin
                            rx.valid <= 1'b1;
                            rx.data <= assembly;
                        end else begin
                            // bad stop bit, old data stays
                            rx.frameError <= 1'b1;
                        end
                        state <= idleState;
                    end
                end
                default: state <= idleState;
            endcase
        end
    end

    // bits arrive LSB first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == dataState && tick) begin
            assembly <= {rxLine, assembly[uartPkg::DATA_BITS-1:1]};
        end
    end

endmodule

// ==== source/uartCore.sv ====
`timescale 1ns/1ps

module uartCore #(
    // bit period is 2**accWidth / baudIncrement clocks
    parameter int accWidth = uartPkg::DEFAULT_ACC_WIDTH,
    parameter int baudIncrement = uartPkg::DEFAULT_INCREMENT,
    // about half of the bit period, receiver only
    parameter int halfBitCycles = uartPkg::DEFAULT_HALF_BIT
) (
    input logic clk,
    input logic rst,
    input uartPkg::txReq tx,
    output logic txBusy,
    output logic txLine,
    input logic rxLine,
    output uartPkg::rxResult rx
);

    // transmit path, idle high
    uartTx #(
        .accWidth(accWidth),
        .baudIncrement(baudIncrement)
    ) u_tx (
        .clk(clk),
        .rst(rst),
        .tx(tx),
        .txLine(txLine),
        .txBusy(txBusy)
    );

    // receive path, each side has its own bit timer
    uartRx #(
        .accWidth(accWidth),
        .baudIncrement(baudIncrement),
        .halfBitCycles(halfBitCycles)
    ) u_rx (
        .clk(clk),
        .rst(rst),
        .rxLine(rxLine),
        .rx(rx)
    );

endmodule

// ==== verif/uartCoreTb.sv ====
`timescale 1ns/1ps

module uartCoreTb;

    // bit period with the default parameters, in clock cycles
    localparam int bitCycles = 16;
    localparam int maxRecords = 64;

    logic clk;
    logic rst;
    uartPkg::txReq txIn;
    logic txBusy;
    logic txLine;
    logic rxLine;
    uartPkg::rxResult rxOut;

    // rxLine comes from the loopback or the bit-bang driver
    logic useLoop;
    logic directLine;

    int validSeen = 0;
    int frameErrSeen = 0;
    int errorTotal = 0;
    int passCount = 0;
    int failCount = 0;
    bit testFailed = 0;
    int cycleCount = 0;
    int cycleLimit = 100;

    // parsed records with mode 0 for loop, 1 for direct and 2 for glitch
    int recordCount = 0;
    int modeList [maxRecords];
    logic [7:0] dataList [maxRecords];
    logic stopList [maxRecords];
    int glitchList [maxRecords];
    bit wantValidList [maxRecords];
    logic [7:0] rxDataList [maxRecords];

    assign rxLine = useLoop ? txLine : directLine;

    uartCore u_dut (
        .clk(clk),
        .rst(rst),
        .tx(txIn),
        .txBusy(txBusy),
        .txLine(txLine),
        .rxLine(rxLine),
        .rx(rxOut)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // pulses counted at the edge that ends them
    always @(posedge clk) begin
        if (!rst) begin
            if (rxOut.valid) begin
                validSeen++;
            end
            if (rxOut.frameError) begin
                frameErrSeen++;
            end
        end
    end

    initial begin
        @(posedge clk);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("run stopped after %0d cycles without finishing", cycleCount);
        $display("Errors found");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, actual, expected);
            errorTotal++;
            testFailed = 1'b1;
        end
    endtask

    task automatic reportTest(input int num, input string label);
        if (testFailed) begin
            failCount++;
            $display("test %0d (%s) failed", num, label);
        end else begin
            passCount++;
            $display("test %0d (%s) passed", num, label);
        end
        testFailed = 1'b0;
    endtask

    function automatic string modeName(input int code);
        case (code)
            0: return "loop";
            1: return "direct";
            default: return "glitch";
        endcase
    endfunction

    task automatic readStimulus();
        int fd;
        int fields;
        int stopVal;
        int glitchVal;
        logic [8*96-1:0] lineText;
        logic [63:0] modeWord;
        logic [63:0] resultWord;
        logic [7:0] dataVal;
        logic [7:0] rxVal;
        fd = $fopen("verif/uartStim.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/uartStim.txt");
            errorTotal++;
        end else begin
            while ($fgets(lineText, fd) != 0) begin
                fields = $sscanf(lineText, "%s %h %d %d %s %h", modeWord, dataVal,
                                 stopVal, glitchVal, resultWord, rxVal);
                // comment and blank lines do not give six fields
                if (fields == 6 && recordCount < maxRecords) begin
                    if (modeWord == "loop") begin
                        modeList[recordCount] = 0;
                    end else if (modeWord == "direct") begin
                        modeList[recordCount] = 1;
                    end else if (modeWord == "glitch") begin
                        modeList[recordCount] = 2;
                    end else begin
                        $display("unknown mode in stimulus record %0d", recordCount + 1);
                        errorTotal++;
                        continue;
                    end
                    dataList[recordCount] = dataVal;
                    stopList[recordCount] = stopVal[0];
                    glitchList[recordCount] = glitchVal;
                    wantValidList[recordCount] = (resultWord == "valid");
                    rxDataList[recordCount] = rxVal;
                    recordCount++;
                end
            end
            $fclose(fd);
        end
        if (recordCount == 0) begin
            $display("no test records were read");
            errorTotal++;
        end
    endtask

    // start bit, eight data bits LSB first and a stop bit of one period each
    task automatic sendFrame(input logic [7:0] data, input logic stopBit);
        int i;
        directLine = 1'b0;
        repeat (bitCycles) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            directLine = data[i];
            repeat (bitCycles) @(negedge clk);
        end
        directLine = stopBit;
        repeat (bitCycles) @(negedge clk);
        directLine = 1'b1;
    endtask

    task automatic runLoop(input logic [7:0] data);
        int cycleIdx;
        int busyCycles;
        int lateBusy;
        int bitNum;
        logic expBit;
        txIn.start = 1'b1;
        txIn.data = data;
        @(negedge clk);
        cycleIdx = 0;
        busyCycles = 0;
        // cycle 0 is the first low cycle of the start bit
        while (txBusy && cycleIdx < 20 * bitCycles) begin
            busyCycles++;
            if (cycleIdx % bitCycles == bitCycles / 2) begin
                bitNum = cycleIdx / bitCycles;
                if (bitNum == 0) begin
                    expBit = 1'b0;
                end else if (bitNum <= 8) begin
                    expBit = data[bitNum-1];
                end else begin
                    expBit = 1'b1;
                end
                check("txLine", txLine, expBit);
            end
            // a strobe in mid frame must be ignored
            txIn.start = (cycleIdx == 3 * bitCycles);
            txIn.data = ~data;
            @(negedge clk);
            cycleIdx++;
        end
        txIn.start = 1'b0;
        check("txBusy cycles", busyCycles, 10 * bitCycles);
        lateBusy = 0;
        repeat (2 * bitCycles) begin
            @(negedge clk);
            if (txBusy) begin
                lateBusy++;
            end
        end
        check("txBusy after frame", lateBusy, 0);
    endtask

    task automatic runGlitch(input int lowCycles, input logic [7:0] data, input logic stopBit);
        int baseValid;
        int baseErr;
        baseValid = validSeen;
        baseErr = frameErrSeen;
        directLine = 1'b0;
        repeat (lowCycles) @(negedge clk);
        directLine = 1'b1;
        repeat (200 - lowCycles) @(negedge clk);
        check("rx.valid after glitch", validSeen - baseValid, 0);
        check("rx.frameError after glitch", frameErrSeen - baseErr, 0);
        sendFrame(data, stopBit);
    endtask

    task automatic waitResult(input int base);
        int waited;
        waited = 0;
        while (validSeen + frameErrSeen == base && waited < 4 * bitCycles) begin
            @(negedge clk);
            waited++;
        end
        if (validSeen + frameErrSeen == base) begin
            $display("receiver gave no result within %0d cycles of the frame end", waited);
            errorTotal++;
            testFailed = 1'b1;
        end
    endtask

    initial begin
        int idx;
        int baseValid;
        int baseErr;
        int gap;
        void'($urandom(32'hbcc2));
        rst = 1'b1;
        txIn = '0;
        useLoop = 1'b0;
        directLine = 1'b1;
        readStimulus();
        cycleLimit = 400 * recordCount + 100;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        check("txLine", txLine, 1);
        check("txBusy", txBusy, 0);
        check("rx.valid", rxOut.valid, 0);
        check("rx.frameError", rxOut.frameError, 0);
        check("rx.data", rxOut.data, 0);
        reportTest(0, "reset");
        for (idx = 0; idx < recordCount; idx++) begin
            useLoop = (modeList[idx] == 0);
            baseValid = validSeen;
            baseErr = frameErrSeen;
            case (modeList[idx])
                0: runLoop(dataList[idx]);
                1: sendFrame(dataList[idx], stopList[idx]);
                default: runGlitch(glitchList[idx], dataList[idx], stopList[idx]);
            endcase
            waitResult(baseValid + baseErr);
            // receiver back in idle before the next frame
            repeat (bitCycles) @(negedge clk);
            check("rx.valid pulses", validSeen - baseValid, wantValidList[idx]);
            check("rx.frameError pulses", frameErrSeen - baseErr, !wantValidList[idx]);
            check("rx.data", rxOut.data, rxDataList[idx]);
            reportTest(idx + 1, modeName(modeList[idx]));
            gap = $urandom % 21;
            repeat (gap) @(negedge clk);
        end
        $display("tests passed %0d, failed %0d, mismatches %0d", passCount, failCount,
                 errorTotal);
        if (errorTotal == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== verif/uartStim.txt ====
# mode data(hex) stop glitchLen result rxData(hex)
# mode is loop, direct or glitch, result is valid or ferr
loop   5a 1 0 valid 5a
loop   a5 1 0 valid a5
loop   00 1 0 valid 00
loop   ff 1 0 valid ff
direct 96 1 0 valid 96
direct 42 0 0 ferr  96
loop   3c 1 0 valid 3c
glitch c3 1 1 valid c3
glitch 18 1 4 valid 18
glitch 7e 1 7 valid 7e
direct 00 0 0 ferr  7e
loop   81 1 0 valid 81
direct e7 1 0 valid e7
loop   01 1 0 valid 01

// ==== compile.f ====
source/uartPkg.sv
source/baudTick.sv
source/uartTx.sv
source/uartRx.sv
source/uartCore.sv
verif/uartCoreTb.sv
